//--- src/bus_pkg.sv
package bus_pkg;

  localparam int unsigned HOST_ADDR_WIDTH = 11; // Word index width on the host port

  // Core data port request, byte address
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;   // Set for requests outside every enabled window
  } core_rsp_t;

  typedef struct packed {
    logic [HOST_ADDR_WIDTH-1:0] addr; // Word index, not a byte address
    logic                       we;
    logic [3:0]                 be;
    logic [31:0]                wdata;
  } host_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } ext_req_t;

  typedef enum logic {CFG_PREFIX, CFG_CTRL} cfg_sel_e;

endpackage

//--- src/region_pkg.sv
package region_pkg;

  // Top address byte that selects the local data RAM out of reset
  localparam logic [7:0] LOCAL_PREFIX_RST = 8'h10;
  localparam logic       EXT_EN_RST       = 1'b1;

  // Target shared by all responses still in flight
  typedef enum logic [1:0] {
    ROUTE_LOCAL,
    ROUTE_EXT,
    ROUTE_ERR
  } route_state_e;

endpackage

//--- src/data_ram.sv
module data_ram
#(
  parameter int unsigned DATA_ADDR_WIDTH = 11
)
(
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       en_a_i,
  input  logic                       we_a_i,
  input  logic [3:0]                 be_a_i,
  input  logic [DATA_ADDR_WIDTH-1:0] addr_a_i,
  input  logic [31:0]                wdata_a_i,
  output logic [31:0]                rdata_a_o,

  input  logic                       en_b_i,
  input  logic                       we_b_i,
  input  logic [3:0]                 be_b_i,
  input  logic [DATA_ADDR_WIDTH-1:0] addr_b_i,
  input  logic [31:0]                wdata_b_i,
  output logic [31:0]                rdata_b_o,
  output logic                       rvalid_b_o
);

  logic [3:0][7:0] mem [2**DATA_ADDR_WIDTH];

  // A same-word write from both ports in one cycle is undefined
  always_ff @(posedge clk)
  begin
    if (en_a_i)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (we_a_i && be_a_i[i])
          mem[addr_a_i][i] <= wdata_a_i[8*i +: 8];
      end
      rdata_a_o <= mem[addr_a_i]; // Old contents on a write
    end
    if (en_b_i)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (we_b_i && be_b_i[i])
          mem[addr_b_i][i] <= wdata_b_i[8*i +: 8];
      end
      rdata_b_o <= mem[addr_b_i];
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rvalid_b_o <= 1'b0;
    else
      rvalid_b_o <= en_b_i;
  end

endmodule

//--- src/map_regs.sv
module map_regs
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              cfg_valid_i,
  input  logic              cfg_we_i,
  input  bus_pkg::cfg_sel_e cfg_sel_i,
  input  logic [31:0]       cfg_wdata_i,
  output logic [31:0]       cfg_rdata_o,

  output logic [7:0]        prefix_o,
  output logic              ext_en_o
);

  import bus_pkg::*;
  import region_pkg::*;

  logic cfg_write;

  assign cfg_write = cfg_valid_i && cfg_we_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      prefix_o <= LOCAL_PREFIX_RST;
      ext_en_o <= EXT_EN_RST;
    end
    else if (cfg_write)
    begin
      if (cfg_sel_i == CFG_PREFIX)
        prefix_o <= cfg_wdata_i[7:0];
      else
        ext_en_o <= cfg_wdata_i[0]; // Bit 0 of the control word
    end
  end

  always_comb
  begin
    case (cfg_sel_i)
      CFG_PREFIX: cfg_rdata_o = {24'h0, prefix_o};
      default:    cfg_rdata_o = {31'h0, ext_en_o};
    endcase
  end

endmodule

//--- src/data_route.sv
module data_route
#(
  parameter int unsigned DATA_ADDR_WIDTH = 11,
  parameter int unsigned MAX_OUTSTANDING = 4
)
(
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       core_req_valid_i,
  input  bus_pkg::core_req_t         core_req_i,
  output logic                       core_gnt_o,
  output logic                       core_rvalid_o,
  output bus_pkg::core_rsp_t         core_rsp_o,

  input  logic [7:0]                 prefix_i,
  input  logic                       ext_en_i,

  output logic                       ram_en_o,
  output logic                       ram_we_o,
  output logic [3:0]                 ram_be_o,
  output logic [DATA_ADDR_WIDTH-1:0] ram_addr_o,
  output logic [31:0]                ram_wdata_o,
  input  logic [31:0]                ram_rdata_i,

  output logic                       br_req_valid_o,
  input  logic                       br_gnt_i,
  input  logic                       br_rvalid_i,
  input  bus_pkg::core_rsp_t         br_rsp_i
);

  import bus_pkg::*;
  import region_pkg::*;

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  route_state_e     target;
  route_state_e     state_q;
  logic [CNT_W-1:0] out_cnt_q;
  logic             cnt_full;
  logic             issue;
  logic             local_gnt;
  logic             err_gnt;
  logic             local_rvalid_q;
  logic             err_rvalid_q;

  always_comb
  begin
    if (core_req_i.addr[31:24] == prefix_i)
      target = ROUTE_LOCAL;
    else if (ext_en_i)
      target = ROUTE_EXT;
    else
      target = ROUTE_ERR;
  end

  // A slot freed by this cycle's response can be reused at once
  assign cnt_full = (out_cnt_q == CNT_W'(MAX_OUTSTANDING)) && !core_rvalid_o;

  // Switching target only from an empty pipeline keeps responses in order
  assign issue = core_req_valid_i && !cnt_full && ((out_cnt_q == '0) || (target == state_q));

  assign local_gnt      = issue && (target == ROUTE_LOCAL);
  assign err_gnt        = issue && (target == ROUTE_ERR);
  assign br_req_valid_o = issue && (target == ROUTE_EXT);
  assign core_gnt_o     = local_gnt || err_gnt || br_gnt_i;

  assign ram_en_o    = local_gnt;
  assign ram_we_o    = core_req_i.we;
  assign ram_be_o    = core_req_i.be;
  assign ram_addr_o  = core_req_i.addr[DATA_ADDR_WIDTH+1:2];
  assign ram_wdata_o = core_req_i.wdata;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q        <= ROUTE_LOCAL;
      out_cnt_q      <= '0;
      local_rvalid_q <= 1'b0;
      err_rvalid_q   <= 1'b0;
    end
    else
    begin
      if (core_gnt_o)
        state_q <= target;
      local_rvalid_q <= local_gnt;
      err_rvalid_q   <= err_gnt;
      case ({core_gnt_o, core_rvalid_o})
        2'b10:   out_cnt_q <= out_cnt_q + CNT_W'(1);
        2'b01:   out_cnt_q <= out_cnt_q - CNT_W'(1);
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  always_comb
  begin
    core_rsp_o = '0;
    case (state_q)
      ROUTE_LOCAL:
      begin
        core_rvalid_o    = local_rvalid_q;
        core_rsp_o.rdata = ram_rdata_i;
      end
      ROUTE_EXT:
      begin
        core_rvalid_o = br_rvalid_i;
        core_rsp_o    = br_rsp_i;
      end
      default:
      begin
        core_rvalid_o  = err_rvalid_q;
        core_rsp_o.err = 1'b1; // Read data stays zero
      end
    endcase
  end

endmodule

//--- src/ext_bridge.sv
module ext_bridge
#(
  parameter int unsigned MAX_OUTSTANDING = 4
)
(
  input  logic               clk,
  input  logic               rst_n,

  input  logic               br_req_valid_i,
  input  bus_pkg::core_req_t core_req_i,
  output logic               br_gnt_o,
  output logic               br_rvalid_o,
  output bus_pkg::core_rsp_t br_rsp_o,

  output logic               ext_req_valid_o,
  input  logic               ext_req_ready_i,
  output bus_pkg::ext_req_t  ext_req_o,
  input  logic               ext_rsp_valid_i,
  input  bus_pkg::core_rsp_t ext_rsp_i
);

  import bus_pkg::*;

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] flight_q;
  logic             room;

  assign room = flight_q < CNT_W'(MAX_OUTSTANDING);

  // The core holds its request until gnt, so the payload is stable while stalled
  assign ext_req_valid_o = br_req_valid_i && room;
  assign ext_req_o.addr  = core_req_i.addr;
  assign ext_req_o.we    = core_req_i.we;
  assign ext_req_o.be    = core_req_i.be;
  assign ext_req_o.wdata = core_req_i.wdata;

  assign br_gnt_o    = ext_req_valid_o && ext_req_ready_i;
  assign br_rvalid_o = ext_rsp_valid_i;
  assign br_rsp_o    = ext_rsp_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      flight_q <= '0;
    else
    begin
      case ({br_gnt_o, ext_rsp_valid_i})
        2'b10:   flight_q <= flight_q + CNT_W'(1);
        2'b01:   flight_q <= flight_q - CNT_W'(1);
        default: flight_q <= flight_q;
      endcase
    end
  end

endmodule

//--- src/core_region.sv
module core_region
#(
  parameter int unsigned DATA_ADDR_WIDTH = 11,
  parameter int unsigned MAX_OUTSTANDING = 4
)
(
  input  logic               clk,
  input  logic               rst_n,

  input  logic               core_req_valid_i,
  input  bus_pkg::core_req_t core_req_i,
  output logic               core_gnt_o,
  output logic               core_rvalid_o,
  output bus_pkg::core_rsp_t core_rsp_o,

  input  logic               host_req_valid_i,
  input  bus_pkg::host_req_t host_req_i,
  output logic               host_rvalid_o,
  output logic [31:0]        host_rdata_o,

  output logic               ext_req_valid_o,
  input  logic               ext_req_ready_i,
  output bus_pkg::ext_req_t  ext_req_o,
  input  logic               ext_rsp_valid_i,
  input  bus_pkg::core_rsp_t ext_rsp_i,

  input  logic               cfg_valid_i,
  input  logic               cfg_we_i,
  input  bus_pkg::cfg_sel_e  cfg_sel_i,
  input  logic [31:0]        cfg_wdata_i,
  output logic [31:0]        cfg_rdata_o
);

  import bus_pkg::*;

  logic [7:0]                 prefix;
  logic                       ext_en;
  logic                       ram_en;
  logic                       ram_we;
  logic [3:0]                 ram_be;
  logic [DATA_ADDR_WIDTH-1:0] ram_addr;
  logic [31:0]                ram_wdata;
  logic [31:0]                ram_rdata;
  logic                       br_req_valid;
  logic                       br_gnt;
  logic                       br_rvalid;
  core_rsp_t                  br_rsp;

  map_regs map_regs_i
  (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .cfg_valid_i ( cfg_valid_i ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_sel_i   ( cfg_sel_i   ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .prefix_o    ( prefix      ),
    .ext_en_o    ( ext_en      )
  );

  data_route
  #(
    .DATA_ADDR_WIDTH ( DATA_ADDR_WIDTH ),
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  )
  data_route_i
  (
    .clk              ( clk              ),
    .rst_n            ( rst_n            ),
    .core_req_valid_i ( core_req_valid_i ),
    .core_req_i       ( core_req_i       ),
    .core_gnt_o       ( core_gnt_o       ),
    .core_rvalid_o    ( core_rvalid_o    ),
    .core_rsp_o       ( core_rsp_o       ),
    .prefix_i         ( prefix           ),
    .ext_en_i         ( ext_en           ),
    .ram_en_o         ( ram_en           ),
    .ram_we_o         ( ram_we           ),
    .ram_be_o         ( ram_be           ),
    .ram_addr_o       ( ram_addr         ),
    .ram_wdata_o      ( ram_wdata        ),
    .ram_rdata_i      ( ram_rdata        ),
    .br_req_valid_o   ( br_req_valid     ),
    .br_gnt_i         ( br_gnt           ),
    .br_rvalid_i      ( br_rvalid        ),
    .br_rsp_i         ( br_rsp           )
  );

  // Port A serves the core, port B the host or loader
  data_ram
  #(
    .DATA_ADDR_WIDTH ( DATA_ADDR_WIDTH )
  )
  data_mem
  (
    .clk        ( clk                                ),
    .rst_n      ( rst_n                              ),
    .en_a_i     ( ram_en                             ),
    .we_a_i     ( ram_we                             ),
    .be_a_i     ( ram_be                             ),
    .addr_a_i   ( ram_addr                           ),
    .wdata_a_i  ( ram_wdata                          ),
    .rdata_a_o  ( ram_rdata                          ),
    .en_b_i     ( host_req_valid_i                   ),
    .we_b_i     ( host_req_i.we                      ),
    .be_b_i     ( host_req_i.be                      ),
    .addr_b_i   ( DATA_ADDR_WIDTH'(host_req_i.addr)  ),
    .wdata_b_i  ( host_req_i.wdata                   ),
    .rdata_b_o  ( host_rdata_o                       ),
    .rvalid_b_o ( host_rvalid_o                      )
  );

  ext_bridge
  #(
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  )
  ext_bridge_i
  (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .br_req_valid_i  ( br_req_valid    ),
    .core_req_i      ( core_req_i      ),
    .br_gnt_o        ( br_gnt          ),
    .br_rvalid_o     ( br_rvalid       ),
    .br_rsp_o        ( br_rsp          ),
    .ext_req_valid_o ( ext_req_valid_o ),
    .ext_req_ready_i ( ext_req_ready_i ),
    .ext_req_o       ( ext_req_o       ),
    .ext_rsp_valid_i ( ext_rsp_valid_i ),
    .ext_rsp_i       ( ext_rsp_i       )
  );

endmodule

//--- sim/core_region_chk.sv
module core_region_chk
#(
  parameter int unsigned MAX_OUTSTANDING = 4,
  parameter int unsigned CNT_W           = 3
)
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               core_req_valid_i,
  input  bus_pkg::core_req_t core_req_i,
  input  logic               core_gnt_o,
  input  logic               core_rvalid_o,
  input  logic               br_req_valid_o,
  input  logic               br_gnt_i,
  input  logic [CNT_W-1:0]   out_cnt_q
);

  timeunit 1ns;
  timeprecision 1ps;

  rvalid_needs_pending: assert property (@(posedge clk) disable iff (!rst_n)
    core_rvalid_o |-> (out_cnt_q != '0))
    else $error("response with no request outstanding");

  gnt_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    core_gnt_o |-> core_req_valid_i)
    else $error("grant without a valid request");

  count_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= CNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count above its limit");

  // A stalled external request keeps its payload until the transfer
  ext_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (br_req_valid_o && !br_gnt_i) |=> (br_req_valid_o && $stable(core_req_i)))
    else $error("external request changed while stalled");

endmodule

bind data_route core_region_chk
#(
  .MAX_OUTSTANDING ( MAX_OUTSTANDING ),
  .CNT_W           ( CNT_W           )
)
route_chk
(
  .clk              ( clk              ),
  .rst_n            ( rst_n            ),
  .core_req_valid_i ( core_req_valid_i ),
  .core_req_i       ( core_req_i       ),
  .core_gnt_o       ( core_gnt_o       ),
  .core_rvalid_o    ( core_rvalid_o    ),
  .br_req_valid_o   ( br_req_valid_o   ),
  .br_gnt_i         ( br_gnt_i         ),
  .out_cnt_q        ( out_cnt_q        )
);

//--- sim/core_region_tb.sv
module core_region_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import region_pkg::*;

  localparam int unsigned DATA_ADDR_WIDTH = 11;
  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam logic [31:0] SEED            = 32'h8ffd555a;
  localparam int          RST_CYCLES      = 16;
  localparam int          N_OPS           = 24 + 16 + 16 + 16 + 5 + 5; // Operations of all tests

  logic        clk;
  logic        rst_n;
  logic        core_req_valid_i;
  core_req_t   core_req_i;
  logic        core_gnt_o;
  logic        core_rvalid_o;
  core_rsp_t   core_rsp_o;
  logic        host_req_valid_i;
  host_req_t   host_req_i;
  logic        host_rvalid_o;
  logic [31:0] host_rdata_o;
  logic        ext_req_valid_o;
  logic        ext_req_ready_i;
  ext_req_t    ext_req_o;
  logic        ext_rsp_valid_i;
  core_rsp_t   ext_rsp_i;
  logic        cfg_valid_i;
  logic        cfg_we_i;
  cfg_sel_e    cfg_sel_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;

  logic [31:0] rng = SEED;
  logic [31:0] bus_rng = SEED; // Random stream of the external bus model
  string       test_name = "reset";
  core_rsp_t   exp_q [$];
  bit          care_q [$];
  logic [31:0] ram_mirror [logic [DATA_ADDR_WIDTH-1:0]];
  logic [31:0] ext_mirror [logic [29:0]];
  logic [31:0] ext_mem [logic [29:0]];
  core_rsp_t   ext_rsp_q [$];
  int          ext_due_q [$];
  int          cycle = 0;
  int          last_due = 0;
  int          ext_xfers = 0;
  int          ext_expected = 0;
  int          last_waits;
  logic [7:0]  cur_prefix = LOCAL_PREFIX_RST;
  logic        cur_ext_en = 1'b1;

  core_region
  #(
    .DATA_ADDR_WIDTH ( DATA_ADDR_WIDTH ),
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  )
  uut
  (
    .clk              ( clk              ),
    .rst_n            ( rst_n            ),
    .core_req_valid_i ( core_req_valid_i ),
    .core_req_i       ( core_req_i       ),
    .core_gnt_o       ( core_gnt_o       ),
    .core_rvalid_o    ( core_rvalid_o    ),
    .core_rsp_o       ( core_rsp_o       ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_req_i       ( host_req_i       ),
    .host_rvalid_o    ( host_rvalid_o    ),
    .host_rdata_o     ( host_rdata_o     ),
    .ext_req_valid_o  ( ext_req_valid_o  ),
    .ext_req_ready_i  ( ext_req_ready_i  ),
    .ext_req_o        ( ext_req_o        ),
    .ext_rsp_valid_i  ( ext_rsp_valid_i  ),
    .ext_rsp_i        ( ext_rsp_i        ),
    .cfg_valid_i      ( cfg_valid_i      ),
    .cfg_we_i         ( cfg_we_i         ),
    .cfg_sel_i        ( cfg_sel_i        ),
    .cfg_wdata_i      ( cfg_wdata_i      ),
    .cfg_rdata_o      ( cfg_rdata_o      )
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Contents of an external word that was never written
  function automatic logic [31:0] ext_fill(logic [29:0] key);
    return {key, 2'b00} ^ 32'h3c5a_96e1 ^ {key[14:0], key[29:13]};
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rsp(input string what, input core_rsp_t exp, input core_rsp_t act,
                           input bit data_matters);
    if (act.err !== exp.err || (data_matters && act.rdata !== exp.rdata))
      stop_run($sformatf("MISMATCH %s: expected %h, actual %h", what, exp, act));
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      stop_run($sformatf("MISMATCH %s: expected %h, actual %h", what, exp, act));
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp)
      stop_run($sformatf("MISMATCH %s: expected %0d, actual %0d", what, exp, act));
  endtask

  // Every core response is checked here against the queue filled at grant time
  always @(posedge clk)
  begin
    if (rst_n && core_rvalid_o)
    begin
      if (exp_q.size() == 0)
        stop_run("core response arrived with no request pending");
      else
        check_rsp(test_name, exp_q.pop_front(), core_rsp_o, care_q.pop_front());
    end
  end

  // External bus model that accepts transfers at the rising edge
  always @(posedge clk)
  begin : ext_accept
    logic [29:0] key;
    core_rsp_t   rsp;
    int          due;
    cycle++;
    if (rst_n && ext_req_valid_o && ext_req_ready_i)
    begin
      ext_xfers++;
      key = ext_req_o.addr[31:2];
      rsp = '0;
      if (!ext_mem.exists(key))
        ext_mem[key] = ext_fill(key);
      if (ext_req_o.we)
        ext_mem[key] = merge_bytes(ext_mem[key], ext_req_o.wdata, ext_req_o.be);
      else
        rsp.rdata = ext_mem[key];
      bus_rng = xorshift(bus_rng);
      due = cycle + 1 + int'(bus_rng % 4);
      if (due <= last_due)
        due = last_due + 1; // Keep responses in order
      last_due = due;
      ext_rsp_q.push_back(rsp);
      ext_due_q.push_back(due);
    end
  end

  always @(negedge clk)
  begin
    bus_rng         = xorshift(bus_rng);
    ext_req_ready_i = rst_n && (bus_rng[1:0] != 2'b00);
    ext_rsp_valid_i = 1'b0;
    if (ext_due_q.size() != 0 && cycle >= ext_due_q[0])
    begin
      ext_rsp_valid_i = 1'b1;
      ext_rsp_i       = ext_rsp_q.pop_front();
      void'(ext_due_q.pop_front());
    end
  end

  task automatic core_issue(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, input core_rsp_t exp, input bit care);
    @(negedge clk);
    core_req_valid_i = 1'b1;
    core_req_i       = '{addr: addr, we: we, be: be, wdata: wdata};
    last_waits       = 0;
    do
    begin
      @(posedge clk);
      last_waits++;
    end
    while (!core_gnt_o);
    exp_q.push_back(exp);
    care_q.push_back(care);
  endtask

  // Works out the expected response from the tb's own view of the address map
  task automatic core_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata);
    logic [DATA_ADDR_WIDTH-1:0] lkey;
    logic [29:0]                ekey;
    core_rsp_t                  exp;
    bit                         care;
    exp  = '0;
    care = 1'b0;
    if (addr[31:24] == cur_prefix)
    begin
      lkey = addr[DATA_ADDR_WIDTH+1:2];
      if (we)
        ram_mirror[lkey] = merge_bytes(ram_mirror.exists(lkey) ? ram_mirror[lkey] : 32'hx,
                                       wdata, be);
      else
      begin
        exp.rdata = ram_mirror[lkey];
        care      = 1'b1;
      end
    end
    else if (cur_ext_en)
    begin
      ext_expected++;
      ekey = addr[31:2];
      if (!ext_mirror.exists(ekey))
        ext_mirror[ekey] = ext_fill(ekey);
      if (we)
        ext_mirror[ekey] = merge_bytes(ext_mirror[ekey], wdata, be);
      else
      begin
        exp.rdata = ext_mirror[ekey];
        care      = 1'b1;
      end
    end
    else
    begin
      exp.err = 1'b1;
      care    = 1'b1;
    end
    core_issue(addr, we, be, wdata, exp, care);
  endtask

  task automatic core_idle();
    @(negedge clk);
    core_req_valid_i = 1'b0;
  endtask

  task automatic drain();
    core_idle();
    while (exp_q.size() != 0)
      @(posedge clk);
    @(negedge clk);
    check_count("external transfers", ext_expected, ext_xfers);
  endtask

  task automatic host_op(input logic we, input logic [10:0] idx, input logic [3:0] be,
                         input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    host_req_valid_i = 1'b1;
    host_req_i       = '{addr: idx, we: we, be: be, wdata: wdata};
    if (we)
      ram_mirror[idx] = merge_bytes(ram_mirror.exists(idx) ? ram_mirror[idx] : 32'hx,
                                    wdata, be);
    @(negedge clk);
    host_req_valid_i = 1'b0;
    @(posedge clk);
    if (!host_rvalid_o)
      stop_run("host response did not follow one cycle after its request");
    rdata = host_rdata_o;
  endtask

  task automatic cfg_write(input cfg_sel_e sel, input logic [31:0] data);
    @(negedge clk);
    cfg_valid_i = 1'b1;
    cfg_we_i    = 1'b1;
    cfg_sel_i   = sel;
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_valid_i = 1'b0;
    cfg_we_i    = 1'b0;
    check_word("cfg readback", data, cfg_rdata_o);
  endtask

  task automatic local_byte_lanes();
    logic [31:0] addr;
    logic [31:0] r;
    test_name = "local_bytes";
    for (int i = 0; i < 8; i++)
    begin
      addr = {8'h10, 24'(16 + 4 * i)};
      core_access(addr, 1'b1, 4'hf, next_rand());
      r = next_rand();
      core_access(addr, 1'b1, r[3:0], next_rand());
    end
    for (int i = 0; i < 8; i++)
    begin
      core_access({8'h10, 24'(16 + 4 * i)}, 1'b0, 4'h0, 32'h0);
      check_count("local gnt delay", 1, last_waits);
      core_idle();
      @(posedge clk);
      if (!core_rvalid_o)
        stop_run("local read response did not come one cycle after its grant");
    end
    drain();
  endtask

  task automatic host_core_share();
    logic [31:0] data;
    test_name = "host_share";
    for (int i = 40; i < 44; i++)
      host_op(1'b1, 11'(i), 4'hf, next_rand(), data);
    for (int i = 40; i < 44; i++)
      core_access({8'h10, 11'h0, 11'(i), 2'b00}, 1'b0, 4'h0, 32'h0);
    drain();
    for (int i = 50; i < 54; i++)
      core_access({8'h10, 11'h0, 11'(i), 2'b00}, 1'b1, 4'hf, next_rand());
    drain();
    for (int i = 50; i < 54; i++)
    begin
      host_op(1'b0, 11'(i), 4'h0, 32'h0, data);
      check_word("host read of core write", ram_mirror[11'(i)], data);
    end
  endtask

  task automatic ext_stall_traffic();
    logic [31:0] r;
    test_name = "ext_stalls";
    for (int i = 0; i < 16; i++)
    begin
      r = next_rand();
      core_access({8'h80, 16'h0, r[5:0], 2'b00}, r[8], r[12:9], next_rand());
    end
    drain();
  endtask

  task automatic mixed_bursts();
    logic [31:0] r;
    test_name = "interleave";
    for (int i = 0; i < 16; i++)
    begin
      r = next_rand();
      if (r[0])
        core_access({8'h10, 24'(16 + 4 * r[3:1])}, r[4], 4'hf, next_rand());
      else
        core_access({8'h80, 16'h0, r[10:5], 2'b00}, r[4], 4'hf, next_rand());
    end
    drain();
  endtask

  task automatic prefix_move();
    test_name = "prefix_move";
    cfg_write(CFG_PREFIX, 32'h20);
    cur_prefix = 8'h20;
    core_access(32'h2000_0100, 1'b1, 4'hf, 32'hcafe_0123);
    core_access(32'h2000_0100, 1'b0, 4'h0, 32'h0);
    core_access(32'h1000_0100, 1'b0, 4'h0, 32'h0); // Old window now goes outside
    drain();
    cfg_write(CFG_PREFIX, 32'(LOCAL_PREFIX_RST));
    cur_prefix = LOCAL_PREFIX_RST;
  endtask

  task automatic ext_disable();
    test_name = "ext_off";
    cfg_write(CFG_CTRL, 32'h0);
    cur_ext_en = 1'b0;
    core_access(32'h3000_0000, 1'b0, 4'h0, 32'h0);
    core_access(32'h3000_0004, 1'b1, 4'hf, 32'h1234_5678);
    core_access(32'h8000_0008, 1'b0, 4'h0, 32'h0);
    drain();
    cfg_write(CFG_CTRL, 32'h1);
    cur_ext_en = 1'b1;
  endtask

  initial
  begin
    #((RST_CYCLES + N_OPS * 20) * 10);
    stop_run("watchdog expired before the tests completed");
  end

  initial
  begin
    clk              = 1'b0;
    rst_n            = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_i       = '0;
    host_req_valid_i = 1'b0;
    host_req_i       = '0;
    ext_req_ready_i  = 1'b0;
    ext_rsp_valid_i  = 1'b0;
    ext_rsp_i        = '0;
    cfg_valid_i      = 1'b0;
    cfg_we_i         = 1'b0;
    cfg_sel_i        = CFG_PREFIX;
    cfg_wdata_i      = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (core_gnt_o || core_rvalid_o || ext_req_valid_o || host_rvalid_o)
      stop_run("an output handshake was high right after reset");
    check_word("reset prefix", 32'(LOCAL_PREFIX_RST), cfg_rdata_o);
    cfg_sel_i = CFG_CTRL;
    #1;
    check_word("reset ext_en", 32'h1, cfg_rdata_o);
    local_byte_lanes();
    host_core_share();
    ext_stall_traffic();
    mixed_bursts();
    prefix_move();
    ext_disable();
    if (exp_q.size() != 0)
      stop_run("core responses still pending at the end of the run");
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- core_region.f
src/bus_pkg.sv
src/region_pkg.sv
src/data_ram.sv
src/map_regs.sv
src/data_route.sv
src/ext_bridge.sv
src/core_region.sv
sim/core_region_chk.sv
sim/core_region_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_region_tb
FILELIST  := core_region.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
